// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module lstm_tb -f flist.f
	./obj_dir/Vlstm_tb | tee sim.log
	grep -qF "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== act_pwl.sv ====
`timescale 1ns/1ps
`include "lstm_macros.svh"

module act_pwl
	import lstm_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  act_sel_t sel,
	input  word_t    arg,
	output word_t    res
);

	localparam word_t ONE = word_t'(1 << `LSTM_FRAC);

	act_arg_u           mag;
	word_t              lo;
	word_t              hi;
	word_t              y;
	word_t              y_next;
	logic signed [31:0] diff;
	logic signed [31:0] fr;
	logic signed [31:0] prod;

	always_comb
	begin
		if (!arg[`LSTM_W-1])
			mag.raw = arg;
		else if (arg == 16'sh8000)
			mag.raw = 16'sh7fff;   // |-16| does not fit
		else
			mag.raw = -arg;

		if (mag.pwl.seg < 4'd8)
		begin
			lo = (sel == SIGMOID) ? sig_tab[mag.pwl.seg] : tanh_tab[mag.pwl.seg];
			hi = (sel == SIGMOID) ? sig_tab[mag.pwl.seg + 4'd1] : tanh_tab[mag.pwl.seg + 4'd1];
		end
		else
		begin
			lo = (sel == SIGMOID) ? sig_tab[8] : tanh_tab[8];   // Flat tail
			hi = lo;
		end

		diff = hi - lo;
		fr = 32'(mag.pwl.frac);
		prod = (diff * fr) >>> `LSTM_FRAC;
		y = lo + prod[`LSTM_W-1:0];

		if (!arg[`LSTM_W-1])
			y_next = y;
		else if (sel == SIGMOID)
			y_next = ONE - y;   // sig(-x) = 1 - sig(x)
		else
			y_next = -y;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			res <= '0;
		else
			res <= y_next;
	end

endmodule

// ==== flist.f ====
+incdir+.
lstm_pkg.sv
state_ram.sv
act_pwl.sv
lstm_cell.sv
lstm_sequencer.sv
lstm_datapath.sv
lstm_sva.sv
lstm_tb.sv

// ==== lstm_cell.sv ====
`timescale 1ns/1ps
`include "lstm_macros.svh"

module lstm_cell
	import lstm_pkg::*;
(
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   wgt_we,
	input  logic [`LSTM_WADDR-1:0] wgt_addr,
	input  word_t                  wgt_data,
	input  logic                   start,
	input  logic [1:0]             slot,
	input  word_t                  u0,
	input  word_t                  u1,
	input  word_t                  r0,
	input  word_t                  r1,
	input  word_t                  c_prev,
	output logic                   done,
	output word_t                  h_new,
	output word_t                  c_new
);

	localparam logic [3:0] PH_IDLE    = 4'd0;
	localparam logic [3:0] PH_MAC_END = 4'(`LSTM_NTERM);
	localparam logic [3:0] PH_ACT1    = PH_MAC_END + 4'd2;
	localparam logic [3:0] PH_CUPD    = PH_MAC_END + 4'd3;
	localparam logic [3:0] PH_TANH    = PH_MAC_END + 4'd4;
	localparam logic [3:0] PH_DONE    = PH_MAC_END + 4'd5;
	localparam word_t      ONE        = word_t'(1 << `LSTM_FRAC);

	word_t                  wmem [`LSTM_NWGT];
	word_t                  wsel [`LSTM_GATES];
	word_t                  acc [`LSTM_GATES];
	word_t                  op_q [4];
	word_t                  cprev_q;
	logic [1:0]             slot_q;
	logic [3:0]             phase;
	logic [2:0]             tidx;
	logic [`LSTM_WADDR-1:0] wbase;
	logic                   mac;
	word_t                  term;
	word_t                  i_q;
	word_t                  g_q;
	word_t                  o_q;
	word_t                  c_q;
	word_t                  arg_a;
	word_t                  arg_b;
	word_t                  res_a;
	word_t                  res_b;
	act_sel_t               sel_b;

	function automatic logic signed [31:0] qmul(input word_t a, input word_t b);
		logic signed [31:0] p;
		p = a * b;
		return p >>> `LSTM_FRAC;
	endfunction

	function automatic word_t sat(input logic signed [31:0] v);
		word_t r;
		if (v > 32'sd32767)
			r = 16'sh7fff;
		else if (v < -32'sd32768)
			r = 16'sh8000;
		else
			r = v[`LSTM_W-1:0];
		return r;
	endfunction

	always_ff @(posedge clk)
	begin
		if (wgt_we && (wgt_addr < `LSTM_NWGT))
			wmem[wgt_addr] <= wgt_data;
	end

	// One term per cycle, all four gates side by side
	always_comb
	begin
		mac = (phase != PH_IDLE) && (phase <= PH_MAC_END);
		tidx = 3'(phase - 4'd1);
		term = ONE;   // Bias term
		if (tidx < 3'd4)
			term = op_q[tidx[1:0]];
		wbase = `LSTM_WADDR'(slot_q * `LSTM_SLOT_WORDS) + `LSTM_WADDR'(tidx);
		for (int g = 0; g < `LSTM_GATES; g++)
			wsel[g] = wmem[wbase + `LSTM_WADDR'(g * `LSTM_NTERM)];
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			phase <= PH_IDLE;
		else if (phase == PH_IDLE)
		begin
			if (start)
				phase <= 4'd1;
		end
		else if (phase == PH_DONE)
			phase <= PH_IDLE;
		else
			phase <= phase + 4'd1;
	end

	always_ff @(posedge clk)
	begin
		if (start && (phase == PH_IDLE))
		begin
			slot_q <= slot;
			op_q[0] <= u0;
			op_q[1] <= u1;
			op_q[2] <= r0;
			op_q[3] <= r1;
			cprev_q <= c_prev;
			for (int g = 0; g < `LSTM_GATES; g++)
				acc[g] <= '0;
		end
		else if (mac)
		begin
			for (int g = 0; g < `LSTM_GATES; g++)
				acc[g] <= sat(acc[g] + qmul(wsel[g], term));
		end
		if (phase == PH_ACT1)
		begin
			i_q <= res_a;
			g_q <= res_b;
		end
		if (phase == PH_CUPD)
		begin
			o_q <= res_b;
			c_q <= sat(qmul(res_a, cprev_q) + qmul(i_q, g_q));   // res_a is sig(f) here
		end
	end

	// Unit a is always a sigmoid; unit b switches to tanh for g and c
	always_comb
	begin
		arg_a = acc[`GATE_I];   // i and g in the first activation cycle
		arg_b = acc[`GATE_G];
		sel_b = TANH;
		if (phase == PH_ACT1)
		begin
			arg_a = acc[`GATE_F];
			arg_b = acc[`GATE_O];
			sel_b = SIGMOID;
		end
		else if (phase == PH_TANH)
			arg_b = c_q;
	end

	act_pwl u_act_a (
		.clk    (clk),
		.arst_n (arst_n),
		.sel    (SIGMOID),
		.arg    (arg_a),
		.res    (res_a)
	);

	act_pwl u_act_b (
		.clk    (clk),
		.arst_n (arst_n),
		.sel    (sel_b),
		.arg    (arg_b),
		.res    (res_b)
	);

	assign done  = (phase == PH_DONE);
	assign c_new = c_q;
	assign h_new = sat(qmul(o_q, res_b));   // res_b is tanh(c) at PH_DONE

endmodule

// ==== lstm_datapath.sv ====
`timescale 1ns/1ps
`include "lstm_macros.svh"

module lstm_datapath
	import lstm_pkg::*;
(
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   in_valid,
	input  word_t                  in_x0,
	input  word_t                  in_x1,
	output logic                   in_credit,
	output logic                   out_valid,
	output word_t                  out_h,
	input  logic                   out_credit,
	input  logic                   wgt_we,
	input  logic [`LSTM_WADDR-1:0] wgt_addr,
	input  word_t                  wgt_data
);

	logic       cell_start;
	logic [1:0] cell_slot;
	word_t      cell_u0;
	word_t      cell_u1;
	word_t      cell_r0;
	word_t      cell_r1;
	word_t      cell_c_prev;
	logic       cell_done;
	word_t      cell_h;
	word_t      cell_c;
	logic [1:0] h_rd_slot;
	logic [1:0] c_rd_slot;
	word_t      h_rd_data;
	word_t      c_rd_data;
	logic       h_wr_en;
	logic       c_wr_en;
	logic [1:0] wr_slot;

	lstm_sequencer u_seq (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_valid    (in_valid),
		.in_x0       (in_x0),
		.in_x1       (in_x1),
		.in_credit   (in_credit),
		.out_credit  (out_credit),
		.out_valid   (out_valid),
		.out_h       (out_h),
		.cell_start  (cell_start),
		.cell_slot   (cell_slot),
		.cell_u0     (cell_u0),
		.cell_u1     (cell_u1),
		.cell_r0     (cell_r0),
		.cell_r1     (cell_r1),
		.cell_c_prev (cell_c_prev),
		.cell_done   (cell_done),
		.cell_h      (cell_h),
		.cell_c      (cell_c),
		.h_rd_slot   (h_rd_slot),
		.c_rd_slot   (c_rd_slot),
		.h_rd_data   (h_rd_data),
		.c_rd_data   (c_rd_data),
		.h_wr_en     (h_wr_en),
		.c_wr_en     (c_wr_en),
		.wr_slot     (wr_slot)
	);

	lstm_cell u_cell (
		.clk      (clk),
		.arst_n   (arst_n),
		.wgt_we   (wgt_we),
		.wgt_addr (wgt_addr),
		.wgt_data (wgt_data),
		.start    (cell_start),
		.slot     (cell_slot),
		.u0       (cell_u0),
		.u1       (cell_u1),
		.r0       (cell_r0),
		.r1       (cell_r1),
		.c_prev   (cell_c_prev),
		.done     (cell_done),
		.h_new    (cell_h),
		.c_new    (cell_c)
	);

	state_ram h_ram (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_en   (h_wr_en),
		.wr_slot (wr_slot),
		.wr_data (cell_h),
		.rd_slot (h_rd_slot),
		.rd_data (h_rd_data)
	);

	state_ram c_ram (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_en   (c_wr_en),
		.wr_slot (wr_slot),
		.wr_data (cell_c),
		.rd_slot (c_rd_slot),
		.rd_data (c_rd_data)
	);

endmodule

// ==== lstm_macros.svh ====
`ifndef LSTM_MACROS_SVH
`define LSTM_MACROS_SVH

// Q4.11 fixed point
`define LSTM_W          16
`define LSTM_FRAC       11

`define LSTM_SLOTS      3   // L1 cell 0, L1 cell 1, L2 cell 0
`define LSTM_NTERM      5   // Two inputs, two recurrent, bias
`define LSTM_GATES      4

// Weight address = slot * LSTM_SLOT_WORDS + gate * LSTM_NTERM + term
`define LSTM_SLOT_WORDS 20
`define LSTM_NWGT       60
`define LSTM_WADDR      6

`define GATE_I          0
`define GATE_F          1
`define GATE_G          2
`define GATE_O          3

`define IN_CREDITS      2   // Input buffer depth
`define OUT_CREDITS_MAX 4

`endif

// ==== lstm_pkg.sv ====
`include "lstm_macros.svh"

package lstm_pkg;

	typedef logic signed [`LSTM_W-1:0] word_t;

	// Raw word, or magnitude split into integer segment and fraction
	typedef union packed {
		word_t raw;
		struct packed {
			logic                  sign;
			logic [3:0]            seg;
			logic [`LSTM_FRAC-1:0] frac;
		} pwl;
	} act_arg_u;

	typedef enum logic {
		SIGMOID,
		TANH
	} act_sel_t;

	// f(k) for k = 0..8, Q4.11
	localparam word_t sig_tab [0:8] = '{
		16'sd1024, 16'sd1497, 16'sd1804,
		16'sd1951, 16'sd2011, 16'sd2034,
		16'sd2043, 16'sd2046, 16'sd2047
	};

	localparam word_t tanh_tab [0:8] = '{
		16'sd0,    16'sd1560, 16'sd1974,
		16'sd2038, 16'sd2047, 16'sd2048,
		16'sd2048, 16'sd2048, 16'sd2048
	};

endpackage

// ==== lstm_sequencer.sv ====
`timescale 1ns/1ps
`include "lstm_macros.svh"

module lstm_sequencer
	import lstm_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       in_valid,
	input  word_t      in_x0,
	input  word_t      in_x1,
	output logic       in_credit,
	input  logic       out_credit,
	output logic       out_valid,
	output word_t      out_h,
	output logic       cell_start,
	output logic [1:0] cell_slot,
	output word_t      cell_u0,
	output word_t      cell_u1,
	output word_t      cell_r0,
	output word_t      cell_r1,
	output word_t      cell_c_prev,
	input  logic       cell_done,
	input  word_t      cell_h,
	input  word_t      cell_c,
	output logic [1:0] h_rd_slot,
	output logic [1:0] c_rd_slot,
	input  word_t      h_rd_data,
	input  word_t      c_rd_data,
	output logic       h_wr_en,
	output logic       c_wr_en,
	output logic [1:0] wr_slot
);

	localparam int         PW   = $clog2(`IN_CREDITS);
	localparam int         FW   = $clog2(`IN_CREDITS + 1);
	localparam int         CW   = $clog2(`OUT_CREDITS_MAX + 1);
	localparam logic [1:0] LAST = 2'(`LSTM_SLOTS - 1);

	localparam logic [2:0] S_IDLE  = 3'd0;
	localparam logic [2:0] S_RD0   = 3'd1;
	localparam logic [2:0] S_RD1   = 3'd2;
	localparam logic [2:0] S_START = 3'd3;
	localparam logic [2:0] S_WAIT  = 3'd4;
	localparam logic [2:0] S_OUT   = 3'd5;

	word_t         fifo_x0 [`IN_CREDITS];
	word_t         fifo_x1 [`IN_CREDITS];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [FW-1:0] fill;
	logic          pop;
	logic [CW-1:0] out_credits;
	logic [2:0]    state;
	logic [1:0]    slot;
	logic          wb;
	word_t         smp_x0;
	word_t         smp_x1;
	word_t         h_a;
	word_t         hn0;
	word_t         hn1;
	word_t         out_h_q;

	assign pop = (state == S_IDLE) && (fill != '0);
	assign wb  = (state == S_WAIT) && cell_done;

	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			fifo_x0[wr_ptr] <= in_x0;
			fifo_x1[wr_ptr] <= in_x1;
		end
		if (pop)
		begin
			smp_x0 <= fifo_x0[rd_ptr];
			smp_x1 <= fifo_x1[rd_ptr];
		end
		if ((state == S_RD1) && (slot != 2'd1))
			h_a <= h_rd_data;   // Old h0 for slots 0 and 1, own h for slot 2
		if (wb && (slot == 2'd0))
			hn0 <= cell_h;
		if (wb && (slot == 2'd1))
			hn1 <= cell_h;
		if (wb && (slot == LAST))
			out_h_q <= cell_h;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			in_credit <= 1'b0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= (wr_ptr == PW'(`IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PW'(`IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			fill <= fill + FW'(in_valid) - FW'(pop);
			in_credit <= pop;   // Slot freed, hand it back
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_credits <= '0;
		else if (out_credit && !out_valid && (out_credits != CW'(`OUT_CREDITS_MAX)))
			out_credits <= out_credits + 1'b1;
		else if (!out_credit && out_valid)
			out_credits <= out_credits - 1'b1;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= S_IDLE;
			slot <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (fill != '0)
					begin
						state <= S_RD0;
						slot <= '0;
					end
				end
				S_RD0:   state <= S_RD1;
				S_RD1:   state <= S_START;
				S_START: state <= S_WAIT;
				S_WAIT:
				begin
					if (cell_done && (slot == LAST))
						state <= S_OUT;
					else if (cell_done)
					begin
						slot <= slot + 2'd1;
						state <= S_RD0;
					end
				end
				S_OUT:
				begin
					if (out_credits != '0)
						state <= S_IDLE;   // Held here without credit
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign h_rd_slot = (state == S_RD1) ? 2'd1 : ((slot == LAST) ? LAST : 2'd0);
	assign c_rd_slot = slot;

	assign cell_start  = (state == S_START);
	assign cell_slot   = slot;
	assign cell_u0     = (slot == LAST) ? hn0 : smp_x0;   // Layer two eats this step's h
	assign cell_u1     = (slot == LAST) ? hn1 : smp_x1;
	assign cell_r0     = h_a;
	assign cell_r1     = (slot == LAST) ? '0 : h_rd_data;   // h1 is still last step's
	assign cell_c_prev = c_rd_data;

	assign h_wr_en = wb;
	assign c_wr_en = wb;
	assign wr_slot = slot;

	assign out_valid = (state == S_OUT) && (out_credits != '0);
	assign out_h     = out_h_q;

endmodule

// ==== lstm_sva.sv ====
`timescale 1ns/1ps
`include "lstm_macros.svh"

module lstm_sva #(
	parameter int CW = $clog2(`OUT_CREDITS_MAX + 1)
) (
	input logic          clk,
	input logic          arst_n,
	input logic [CW-1:0] out_credits,
	input logic          out_credit,
	input logic          out_valid,
	input logic          cell_start,
	input logic          cell_done
);

	logic          busy;
	logic [CW-1:0] granted;   // Credits seen on the port, less results sent

	// High from start up to and including the done cycle
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			busy <= 1'b0;
		else if (cell_start)
			busy <= 1'b1;
		else if (cell_done)
			busy <= 1'b0;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			granted <= '0;
		else
			granted <= granted + CW'(out_credit) - CW'(out_valid);
	end

	credit_count: assert property (@(posedge clk) disable iff (!arst_n)
		(out_credits <= CW'(`OUT_CREDITS_MAX)) && (out_credits == granted))
		else $error("output credit count %0d, credits outstanding %0d",
			out_credits, granted);

	valid_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> (granted != '0))
		else $error("out_valid with no output credit outstanding");

	start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
		cell_start |-> !busy)
		else $error("cell_start while the cell is busy");

endmodule

bind lstm_sequencer lstm_sva u_sva (
	.clk         (clk),
	.arst_n      (arst_n),
	.out_credits (out_credits),
	.out_credit  (out_credit),
	.out_valid   (out_valid),
	.cell_start  (cell_start),
	.cell_done   (cell_done)
);

// ==== lstm_tb.sv ====
`timescale 1ns/1ps
`include "lstm_macros.svh"

module lstm_tb
	import lstm_pkg::*;
();

	localparam int PERIOD     = 40;
	localparam int N_SAMPLES  = 8 + 8 + 20 + 12 + 12 + 8;
	localparam int BP_SAMPLES = 12;
	localparam int N_LOADS    = 5;
	localparam int WATCHDOG_CYCLES = 16 + N_LOADS * 62 + N_SAMPLES * 60 + BP_SAMPLES * 32 + 200;

	logic                   clk;
	logic                   arst_n;
	logic                   in_valid;
	word_t                  in_x0;
	word_t                  in_x1;
	logic                   in_credit;
	logic                   out_valid;
	word_t                  out_h;
	logic                   out_credit;
	logic                   wgt_we;
	logic [`LSTM_WADDR-1:0] wgt_addr;
	word_t                  wgt_data;

	logic [15:0] lfsr;
	int          wgt [`LSTM_NWGT];
	int          h_st [`LSTM_SLOTS];
	int          c_st [`LSTM_SLOTS];
	int          exp_q [$];
	int          in_cred;     // Input credits held by the sender
	int          granted;     // Output credits not yet used by the DUT
	int          sat_hits;
	int          checks;
	int          errors;
	int          test_errs;
	int          tests_run;
	int          tests_failed;

	lstm_datapath dut0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_x0      (in_x0),
		.in_x1      (in_x1),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_h      (out_h),
		.out_credit (out_credit),
		.wgt_we     (wgt_we),
		.wgt_addr   (wgt_addr),
		.wgt_data   (wgt_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic int signed_rand(input int n);
		logic [31:0] v;
		int          r;
		v = lfsr_bits(n);
		r = int'(v);
		if (v[n-1])
			r = r - (1 << n);
		return r;
	endfunction

	function automatic int fx_mul(input int a, input int b);
		return (a * b) >>> `LSTM_FRAC;
	endfunction

	function automatic int clamp16(input int v);
		int r;
		r = v;
		if (v > 32767)
			r = 32767;
		else if (v < -32768)
			r = -32768;
		return r;
	endfunction

	function automatic int activate(input int x, input bit is_tanh);
		int a;
		int seg;
		int frac;
		int lo;
		int hi;
		int y;
		a = (x < 0) ? -x : x;
		seg = a >> `LSTM_FRAC;
		frac = a & ((1 << `LSTM_FRAC) - 1);
		if (seg >= 8)
			y = is_tanh ? tanh_tab[8] : sig_tab[8];
		else
		begin
			lo = is_tanh ? tanh_tab[seg] : sig_tab[seg];
			hi = is_tanh ? tanh_tab[seg + 1] : sig_tab[seg + 1];
			y = lo + (((hi - lo) * frac) >>> `LSTM_FRAC);
		end
		if (x < 0)
			y = is_tanh ? -y : (1 << `LSTM_FRAC) - y;   // Mirror for negative input
		return y;
	endfunction

	function automatic int eval_cell(input int slot, input int u0, input int u1,
	                                 input int r0, input int r1);
		int ops [`LSTM_NTERM];
		int acc [`LSTM_GATES];
		int base;
		int ig;
		int fg;
		int gg;
		int og;
		ops = '{u0, u1, r0, r1, 1 << `LSTM_FRAC};   // Bias times 1.0
		for (int g = 0; g < `LSTM_GATES; g++)
		begin
			acc[g] = 0;
			base = slot * `LSTM_SLOT_WORDS + g * `LSTM_NTERM;
			for (int t = 0; t < `LSTM_NTERM; t++)
				acc[g] = clamp16(acc[g] + fx_mul(wgt[base + t], ops[t]));
			if ((acc[g] > 16384) || (acc[g] < -16384))
				sat_hits++;   // Past +-8.0
		end
		ig = activate(acc[`GATE_I], 1'b0);
		fg = activate(acc[`GATE_F], 1'b0);
		gg = activate(acc[`GATE_G], 1'b1);
		og = activate(acc[`GATE_O], 1'b0);
		c_st[slot] = clamp16(fx_mul(fg, c_st[slot]) + fx_mul(ig, gg));
		return clamp16(fx_mul(og, activate(c_st[slot], 1'b1)));
	endfunction

	// Layer one sees last step's h, layer two this step's
	function automatic int model_step(input int x0, input int x1);
		int h0;
		int h1;
		int h2;
		h0 = eval_cell(0, x0, x1, h_st[0], h_st[1]);
		h1 = eval_cell(1, x0, x1, h_st[0], h_st[1]);
		h2 = eval_cell(2, h0, h1, h_st[2], 0);
		h_st[0] = h0;
		h_st[1] = h1;
		h_st[2] = h2;
		return h2;
	endfunction

	task automatic load_weights(input int bits);
		for (int a = 0; a < `LSTM_NWGT; a++)
		begin
			@(negedge clk);
			wgt[a] = (bits == 0) ? 0 : signed_rand(bits);
			wgt_we = 1'b1;
			wgt_addr = `LSTM_WADDR'(a);
			wgt_data = word_t'(wgt[a]);
		end
		@(negedge clk);
		wgt_we = 1'b0;
	endtask

	task automatic apply_reset(input int cycles);
		@(negedge clk);
		arst_n = 1'b0;
		repeat (cycles) @(negedge clk);
		arst_n = 1'b1;
		for (int s = 0; s < `LSTM_SLOTS; s++)
		begin
			h_st[s] = 0;
			c_st[s] = 0;
		end
		in_cred = `IN_CREDITS;
		granted = 0;
		exp_q.delete();
	endtask

	task automatic run_stream(input int n, input int in_bits, input bit hold_credits);
		int sent;
		int got;
		int wait_cnt;
		int x0;
		int x1;
		int exp_h;
		sent = 0;
		got = 0;
		wait_cnt = 0;
		while (got < n)
		begin
			@(negedge clk);
			if (in_credit)
				in_cred++;
			if (in_cred > `IN_CREDITS)
			begin
				$display("More input credits returned than samples were sent");
				test_errs++;
				in_cred = `IN_CREDITS;
			end
			if (out_valid)
			begin
				checks++;
				if (granted == 0)
				begin
					$display("out_valid asserted while no output credit was granted");
					test_errs++;
				end
				else
					granted--;
				if (exp_q.size() == 0)
				begin
					$display("Result arrived with no sample outstanding");
					test_errs++;
				end
				else
				begin
					exp_h = exp_q.pop_front();
					if (out_h !== word_t'(exp_h))
					begin
						$display("FAILED out_h result %0d: got %h expected %h",
							got, out_h, word_t'(exp_h));
						test_errs++;
					end
				end
				got++;
			end
			in_valid = 1'b0;
			out_credit = 1'b0;
			if ((sent < n) && (in_cred > 0))
			begin
				x0 = signed_rand(in_bits);
				x1 = signed_rand(in_bits);
				in_valid = 1'b1;
				in_x0 = word_t'(x0);
				in_x1 = word_t'(x1);
				exp_q.push_back(model_step(x0, x1));
				in_cred--;
				sent++;
			end
			if (hold_credits)
			begin
				if (wait_cnt > 0)
					wait_cnt--;
				else if ((granted == 0) && (got < n))
				begin
					out_credit = 1'b1;   // One credit, then a random gap
					granted++;
					wait_cnt = lfsr_bits(5);
				end
			end
			else if ((granted < `OUT_CREDITS_MAX) && (granted < n - got))
			begin
				out_credit = 1'b1;
				granted++;
			end
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (test_errs == 0)
			$display("test %0d %s: passed", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, test_errs);
		end
		errors += test_errs;
		test_errs = 0;
	endtask

	initial
	begin
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_x0 = '0;
		in_x1 = '0;
		out_credit = 1'b0;
		wgt_we = 1'b0;
		wgt_addr = '0;
		wgt_data = '0;
		lfsr = 16'd83;
		sat_hits = 0;
		checks = 0;
		errors = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		apply_reset(16);

		load_weights(0);
		run_stream(8, 13, 1'b0);
		report_test("zero weights");

		load_weights(11);   // About +-0.5
		run_stream(8, 13, 1'b0);
		report_test("random weights");

		run_stream(20, 13, 1'b0);
		report_test("state carry-over");

		load_weights(16);
		sat_hits = 0;
		run_stream(12, 16, 1'b0);
		if (sat_hits == 0)
		begin
			$display("Saturation stimulus never pushed a gate sum past 8.0");
			test_errs++;
		end
		report_test("saturation");

		load_weights(11);
		run_stream(BP_SAMPLES, 13, 1'b1);
		report_test("output back-pressure");

		load_weights(11);
		apply_reset(3);
		run_stream(8, 13, 1'b0);
		report_test("reload and reset");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Timeout after %0d cycles, the DUT stopped delivering results", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== state_ram.sv ====
`timescale 1ns/1ps
`include "lstm_macros.svh"

module state_ram
	import lstm_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       wr_en,
	input  logic [1:0] wr_slot,
	input  word_t      wr_data,
	input  logic [1:0] rd_slot,
	output word_t      rd_data
);

	word_t mem [`LSTM_SLOTS];

	// Reset gives h0 = c0 = 0 for a new sequence
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `LSTM_SLOTS; i++)
				mem[i] <= '0;
			rd_data <= '0;
		end
		else
		begin
			if (wr_en && (wr_slot < `LSTM_SLOTS))
				mem[wr_slot] <= wr_data;
			if (rd_slot < `LSTM_SLOTS)
				rd_data <= mem[rd_slot];   // Old value on same-slot write
			else
				rd_data <= '0;
		end
	end

endmodule
